//--- list.f
+incdir+.
vga_pkg.sv
pipe_delay.sv
char_rom_16x16.sv
font_rom.sv
vga_timing.sv
draw_rect_char.sv
vga_overlay_top.sv
tb_vga_overlay.sv

//--- Bender.yml
package:
  name: vga_overlay

export_include_dirs:
  - .

sources:
  - files:
      - vga_pkg.sv
      - pipe_delay.sv
      - char_rom_16x16.sv
      - font_rom.sv
      - vga_timing.sv
      - draw_rect_char.sv
      - vga_overlay_top.sv
  - target: test
    files:
      - tb_vga_overlay.sv

//--- tb_vga_overlay.sv
`timescale 1ns/100ps
`include "vga_cfg.svh"

module tb_vga_overlay;

  import vga_pkg::*;

  localparam int FRAME   = `H_TOTAL * `V_TOTAL;
  localparam int TIMEOUT = 2 * FRAME;
  localparam int N_TABLE = 18;
  localparam int N_BG    = 200;

  typedef struct packed {
    logic [10:0] h;
    logic [10:0] v;
    logic [11:0] rgb;
  } pix_check_t;

  logic clk;
  logic rst_n;
  logic hsync;
  logic vsync;
  rgb_t rgb;

  int         out_h;  // pixel now at the outputs.
  int         out_v;
  int         edges;
  int         errors;
  int         test_errors;
  int         tests_run;
  int         tests_failed;
  pix_check_t pix_table [N_TABLE];
  bit         bg_mark [`H_VISIBLE * `V_VISIBLE];

  vga_overlay_top dut (
    .clk  (clk),
    .rst_n(rst_n),
    .hsync(hsync),
    .vsync(vsync),
    .rgb  (rgb)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // trails the timing counters by three clocks.
  always @(posedge clk) begin
    if (!rst_n) begin
      out_h <= `H_TOTAL - 3;
      out_v <= `V_TOTAL - 1;
      edges <= 0;
    end else begin
      edges <= edges + 1;
      if (out_h == `H_TOTAL - 1) begin
        out_h <= 0;
        out_v <= (out_v == `V_TOTAL - 1) ? 0 : out_v + 1;
      end else begin
        out_h <= out_h + 1;
      end
    end
  end

  function automatic bit inside_rect(input int h, input int v);
    return (h >= `RECT_X) && (h < `RECT_X + `RECT_W) &&
           (v >= `RECT_Y) && (v < `RECT_Y + `RECT_H);
  endfunction

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("error: %s got %h expected %h at pixel (%0d,%0d)",
               name, actual, expected, out_h, out_v);
      errors++;
      test_errors++;
    end
  endtask

  task automatic wait_pixel(input int h, input int v);
    int count;
    count = 0;
    @(negedge clk);
    while (!(edges >= 3 && out_h == h && out_v == v)) begin
      if (count > TIMEOUT) begin
        $display("timeout, pixel (%0d,%0d) never reached the outputs", h, v);
        $display("TEST FAILED");
        $finish;
      end else begin
        count++;
        @(negedge clk);
      end
    end
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (test_errors != 0) begin
      tests_failed++;
    end
    $display("test %s: %s, %0d errors", name, (test_errors == 0) ? "pass" : "fail",
             test_errors);
    test_errors = 0;
  endtask

  // raster order, so one frame reaches them all.
  task automatic load_table();
    pix_table[0]  = {11'd63,  11'd32,  `BG_RGB};    // left of the corner.
    pix_table[1]  = {11'd64,  11'd32,  `TEXT_RGB};  // top left corner.
    pix_table[2]  = {11'd100, 11'd40,  `TEXT_RGB};
    pix_table[3]  = {11'd700, 11'd40,  12'h000};    // h blank.
    pix_table[4]  = {11'd70,  11'd48,  `RECT_RGB};  // row 1, glyph line 0.
    pix_table[5]  = {11'd100, 11'd49,  `RECT_RGB};
    pix_table[6]  = {11'd90,  11'd62,  `RECT_RGB};
    pix_table[7]  = {11'd80,  11'd63,  `RECT_RGB};
    pix_table[8]  = {11'd64,  11'd64,  `RECT_RGB};  // row 2 spaces.
    pix_table[9]  = {11'd120, 11'd150, `RECT_RGB};
    pix_table[10] = {11'd191, 11'd271, `RECT_RGB};  // row 14.
    pix_table[11] = {11'd64,  11'd272, `TEXT_RGB};  // bottom block row.
    pix_table[12] = {11'd191, 11'd287, `TEXT_RGB};
    pix_table[13] = {11'd192, 11'd287, `BG_RGB};
    pix_table[14] = {11'd639, 11'd300, `BG_RGB};
    pix_table[15] = {11'd320, 11'd479, `BG_RGB};
    pix_table[16] = {11'd100, 11'd480, 12'h000};    // v blank.
    pix_table[17] = {11'd799, 11'd524, 12'h000};
  endtask

  initial begin
    int seed;
    int rnd;
    int h;
    int v;
    int picked;
    int checked;
    int hits [16];
    rst_n = 1'b0;
    errors = 0;
    test_errors = 0;
    tests_run = 0;
    tests_failed = 0;
    seed = 32'h65a;
    rnd = $urandom(seed);
    load_table();
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    check_value("rgb", rgb, 12'h000);
    check_value("hsync", hsync, 1'b1);
    check_value("vsync", vsync, 1'b1);
    end_test("reset");

    wait_pixel(0, 0);
    for (int i = 0; i < FRAME; i++) begin
      check_value("hsync", hsync, !(out_h >= `H_SYNC_START && out_h < `H_SYNC_END));
      check_value("vsync", vsync, !(out_v >= `V_SYNC_START && out_v < `V_SYNC_END));
      @(negedge clk);
    end
    end_test("sync_timing");

    for (int i = 0; i < N_TABLE; i++) begin
      wait_pixel(pix_table[i].h, pix_table[i].v);
      check_value("rgb", rgb, pix_table[i].rgb);
    end
    end_test("pixel_table");

    // glyph lines 2 to 13 of grid row 1.
    for (int c = 0; c < 16; c++) begin
      hits[c] = 0;
    end
    for (v = `RECT_Y + 18; v < `RECT_Y + 30; v++) begin
      wait_pixel(`RECT_X, v);
      for (int k = 0; k < `RECT_W; k++) begin
        if (rgb === rgb_t'(`TEXT_RGB)) begin
          hits[k / 8]++;
        end
        @(negedge clk);
      end
    end
    for (int c = 0; c < 16; c++) begin
      check_value($sformatf("cell%0d_text", c), hits[c] > 0, c < 8);
    end
    end_test("text_presence");

    picked = 0;
    while (picked < N_BG) begin
      h = $urandom % `H_VISIBLE;
      v = $urandom % `V_VISIBLE;
      if (!inside_rect(h, v) && !bg_mark[v * `H_VISIBLE + h]) begin
        bg_mark[v * `H_VISIBLE + h] = 1'b1;
        picked++;
      end
    end
    checked = 0;
    wait_pixel(0, 0);
    for (int i = 0; i < FRAME; i++) begin
      if (out_h < `H_VISIBLE && out_v < `V_VISIBLE &&
          bg_mark[out_v * `H_VISIBLE + out_h]) begin
        check_value("rgb", rgb, `BG_RGB);
        checked++;
      end
      @(negedge clk);
    end
    check_value("bg_points", checked, N_BG);
    end_test("background");

    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

//--- vga_overlay_top.sv
`timescale 1ns/100ps

module vga_overlay_top (
  input  logic          clk,
  input  logic          rst_n,
  output logic          hsync,
  output logic          vsync,
  output vga_pkg::rgb_t rgb
);

  import vga_pkg::*;

  vga_bus_t timing_bus;

  vga_timing u_vga_timing (
    .clk    (clk),
    .rst_n  (rst_n),
    .vga_out(timing_bus)
  );

  // three clocks from counters to pins.
  draw_rect_char u_draw_rect_char (
    .clk   (clk),
    .rst_n (rst_n),
    .vga_in(timing_bus),
    .hsync (hsync),
    .vsync (vsync),
    .rgb   (rgb)
  );

endmodule

//--- draw_rect_char.sv
`timescale 1ns/100ps
`include "vga_cfg.svh"

module draw_rect_char (
  input  logic              clk,
  input  logic              rst_n,
  input  vga_pkg::vga_bus_t vga_in,
  output logic              hsync,
  output logic              vsync,
  output vga_pkg::rgb_t     rgb
);

  import vga_pkg::*;

  typedef struct packed {
    logic       in_rect;
    logic       blank;
    logic [2:0] col;  // pixel within the cell.
  } pix_info_t;

  localparam sync_t     SYNC_IDLE = '{hsync: 1'b1, vsync: 1'b1};
  localparam pix_info_t PIX_IDLE  = '{in_rect: 1'b0, blank: 1'b1, col: 3'd0};

  logic [10:0] rel_x;
  logic [10:0] rel_y;
  logic        in_rect;
  logic [7:0]  char_xy;
  logic [3:0]  char_line;
  char_code_t  char_code;
  logic [7:0]  char_pixels;
  pix_info_t   pix_s1;
  pix_info_t   pix_s2;
  sync_t       sync_s1;
  sync_t       sync_out;

  assign rel_x   = vga_in.hcount - 11'(`RECT_X);
  assign rel_y   = vga_in.vcount - 11'(`RECT_Y);
  assign in_rect = (vga_in.hcount >= `RECT_X) && (vga_in.hcount < (`RECT_X + `RECT_W)) &&
                   (vga_in.vcount >= `RECT_Y) && (vga_in.vcount < (`RECT_Y + `RECT_H));

  // cycle 1, ROM address.
  always_ff @(posedge clk) begin
    char_xy   <= {rel_y[7:4], rel_x[6:3]};
    char_line <= rel_y[3:0];
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pix_s1  <= PIX_IDLE;
      sync_s1 <= SYNC_IDLE;
    end else begin
      pix_s1  <= '{in_rect: in_rect, blank: vga_in.blank, col: rel_x[2:0]};
      sync_s1 <= '{hsync: vga_in.hsync, vsync: vga_in.vsync};
    end
  end

  char_rom_16x16 u_char_rom (
    .char_xy  (char_xy),
    .char_code(char_code)
  );

  // cycle 2, glyph row.
  font_rom u_font_rom (
    .clk        (clk),
    .rst_n      (rst_n),
    .char_code  (char_code),
    .char_line  (char_line),
    .char_pixels(char_pixels)
  );

  pipe_delay #(.T_DATA(pix_info_t), .DEPTH(1), .RESET_VALUE(PIX_IDLE)) u_pix_delay (
    .clk  (clk),
    .rst_n(rst_n),
    .din  (pix_s1),
    .dout (pix_s2)
  );

  pipe_delay #(.T_DATA(sync_t), .DEPTH(2), .RESET_VALUE(SYNC_IDLE)) u_sync_delay (
    .clk  (clk),
    .rst_n(rst_n),
    .din  (sync_s1),
    .dout (sync_out)
  );

  // cycle 3, colour select.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rgb <= '0;
    end else if (pix_s2.blank) begin
      rgb <= '0;
    end else if (!pix_s2.in_rect) begin
      rgb <= rgb_t'(`BG_RGB);
    end else if (char_pixels[3'd7 - pix_s2.col]) begin  // bit 7 is leftmost.
      rgb <= rgb_t'(`TEXT_RGB);
    end else begin
      rgb <= rgb_t'(`RECT_RGB);
    end
  end

  assign hsync = sync_out.hsync;
  assign vsync = sync_out.vsync;

endmodule

//--- vga_timing.sv
`timescale 1ns/100ps
`include "vga_cfg.svh"

module vga_timing (
  input  logic              clk,
  input  logic              rst_n,
  output vga_pkg::vga_bus_t vga_out
);

  import vga_pkg::*;

  vga_bus_t timing_q;
  vga_bus_t timing_nxt;

  always_comb begin
    timing_nxt = timing_q;
    timing_nxt.hcount = timing_q.hcount + 11'd1;
    if (timing_q.hcount == 11'(`H_TOTAL - 1)) begin
      timing_nxt.hcount = '0;
      if (timing_q.vcount == 11'(`V_TOTAL - 1)) begin
        timing_nxt.vcount = '0;
      end else begin
        timing_nxt.vcount = timing_q.vcount + 11'd1;
      end
    end

    // sync and blank follow the new counter values.
    timing_nxt.hsync = !((timing_nxt.hcount >= `H_SYNC_START) &&
                         (timing_nxt.hcount < `H_SYNC_END));
    timing_nxt.vsync = !((timing_nxt.vcount >= `V_SYNC_START) &&
                         (timing_nxt.vcount < `V_SYNC_END));
    timing_nxt.blank = (timing_nxt.hcount >= `H_VISIBLE) ||
                       (timing_nxt.vcount >= `V_VISIBLE);
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      timing_q.hcount <= '0;
      timing_q.vcount <= '0;
      timing_q.hsync  <= 1'b1;
      timing_q.vsync  <= 1'b1;
      timing_q.blank  <= 1'b0;  // (0,0) is visible.
    end else begin
      timing_q <= timing_nxt;
    end
  end

  assign vga_out = timing_q;

endmodule

//--- font_rom.sv
`timescale 1ns/100ps

module font_rom (
  input  logic                clk,
  input  logic                rst_n,
  input  vga_pkg::char_code_t char_code,
  input  logic [3:0]          char_line,
  output logic [7:0]          char_pixels
);

  import vga_pkg::*;

  // glyph lines 2 to 13, line 2 in the top byte.
  localparam logic [95:0] GLYPH_ZERO  = 96'h7c_c6_c6_ce_de_f6_e6_c6_c6_7c_00_00;
  localparam logic [95:0] GLYPH_ONE   = 96'h18_38_78_18_18_18_18_18_18_7e_00_00;
  localparam logic [95:0] GLYPH_TWO   = 96'h7c_c6_06_0c_18_30_60_c0_c6_fe_00_00;
  localparam logic [95:0] GLYPH_SEVEN = 96'hfe_c6_06_06_0c_18_30_30_30_30_00_00;
  localparam logic [95:0] GLYPH_EIGHT = 96'h7c_c6_c6_c6_7c_c6_c6_c6_c6_7c_00_00;
  localparam logic [95:0] GLYPH_X     = 96'h00_00_00_c6_6c_38_38_38_6c_c6_00_00;

  logic [95:0] glyph;
  logic [3:0]  row_from_bottom;
  logic [7:0]  pixels_nxt;

  assign row_from_bottom = 4'd13 - char_line;

  always_comb begin
    case (char_code)
      zero:    glyph = GLYPH_ZERO;
      one:     glyph = GLYPH_ONE;
      two:     glyph = GLYPH_TWO;
      seven:   glyph = GLYPH_SEVEN;
      eight:   glyph = GLYPH_EIGHT;
      x:       glyph = GLYPH_X;
      default: glyph = '0;  // space and unknown codes.
    endcase
  end

  always_comb begin
    if (char_code == blk) begin
      pixels_nxt = 8'hff;
    end else if (char_line < 4'd2 || char_line > 4'd13) begin
      pixels_nxt = '0;  // top and bottom margin.
    end else begin
      pixels_nxt = glyph[{row_from_bottom, 3'b000} +: 8];
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      char_pixels <= '0;
    end else begin
      char_pixels <= pixels_nxt;
    end
  end

endmodule

//--- char_rom_16x16.sv
`timescale 1ns/100ps

module char_rom_16x16 (
  input  logic [7:0]          char_xy,
  output vga_pkg::char_code_t char_code
);

  import vga_pkg::*;

  logic [3:0] grid_row;
  logic [3:0] grid_col;

  assign grid_row = char_xy[7:4];
  assign grid_col = char_xy[3:0];

  always_comb begin
    char_code = Spc;
    if (grid_row == 4'd0 || grid_row == 4'd15) begin
      char_code = blk;  // top and bottom border.
    end else if (grid_row == 4'd1) begin
      // resolution banner.
      case (grid_col)
        4'd0:    char_code = one;
        4'd1:    char_code = two;
        4'd2:    char_code = eight;
        4'd3:    char_code = zero;
        4'd4:    char_code = x;
        4'd5:    char_code = seven;
        4'd6:    char_code = two;
        4'd7:    char_code = zero;
        default: char_code = Spc;
      endcase
    end
  end

endmodule

//--- pipe_delay.sv
`timescale 1ns/100ps

module pipe_delay #(
  parameter type   T_DATA      = logic,
  parameter int    DEPTH       = 1,
  parameter T_DATA RESET_VALUE = '0
) (
  input  logic  clk,
  input  logic  rst_n,
  input  T_DATA din,
  output T_DATA dout
);

  T_DATA stage_q [DEPTH];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < DEPTH; i++) begin
        stage_q[i] <= RESET_VALUE;
      end
    end else begin
      stage_q[0] <= din;
      for (int i = 1; i < DEPTH; i++) begin
        stage_q[i] <= stage_q[i-1];
      end
    end
  end

  assign dout = stage_q[DEPTH-1];  // oldest stage.

endmodule

//--- vga_pkg.sv
package vga_pkg;

  typedef logic [6:0] char_code_t;

  // one pixel position with its sync and blank state.
  typedef struct packed {
    logic [10:0] hcount;
    logic [10:0] vcount;
    logic        hsync;  // active low.
    logic        vsync;  // active low.
    logic        blank;  // high outside the visible area.
  } vga_bus_t;

  typedef struct packed {
    logic [3:0] red;
    logic [3:0] green;
    logic [3:0] blue;
  } rgb_t;

  typedef struct packed {
    logic hsync;
    logic vsync;
  } sync_t;

  // character codes used by the text map.
  localparam char_code_t Spc   = 7'h20;
  localparam char_code_t zero  = 7'h30;
  localparam char_code_t one   = 7'h31;
  localparam char_code_t two   = 7'h32;
  localparam char_code_t seven = 7'h37;
  localparam char_code_t eight = 7'h38;
  localparam char_code_t x     = 7'h78;
  localparam char_code_t blk   = 7'h0e;  // full block.

endpackage

//--- vga_cfg.svh
`ifndef VGA_CFG_SVH
`define VGA_CFG_SVH

// 640x480 at 60 Hz, counts in pixel clocks and lines.
`define H_VISIBLE    640
`define H_SYNC_START 656
`define H_SYNC_END   752
`define H_TOTAL      800

`define V_VISIBLE    480
`define V_SYNC_START 490
`define V_SYNC_END   492
`define V_TOTAL      525

// text rectangle, 16x16 cells of 8x16 pixels.
`define RECT_X 64
`define RECT_Y 32
`define RECT_W 128
`define RECT_H 256

`define BG_RGB   12'h00f
`define RECT_RGB 12'h000
`define TEXT_RGB 12'hfff

`endif
